// File: hw/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // datapath widths
    localparam int WORD_W = 64;
    localparam int TAG_W  = 6;
    localparam int OP_W   = 4;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [TAG_W-1:0]  tag_t;

    typedef enum logic [OP_W-1:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_ORR = 4'd3,
        OP_EOR = 4'd4,
        OP_MVN = 4'd5,
        OP_ASR = 4'd6,
        OP_LSL = 4'd7,
        OP_MUL = 4'd8
    } op_t;

    // functional-unit queue sizing
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

    // queue entry packed msb to lsb as {op, tag, a, b}
    localparam int ENTRY_W = OP_W + TAG_W + 2 * WORD_W;
    localparam int B_LSB   = 0;
    localparam int A_LSB   = B_LSB + WORD_W;
    localparam int TAG_LSB = A_LSB + WORD_W;
    localparam int OP_LSB  = TAG_LSB + TAG_W;

    typedef logic [ENTRY_W-1:0] entry_t;

    // multiplier pipeline depth
    localparam int MUL_LATENCY = 3;

endpackage

`default_nettype wire

// File: hw/fu_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fu_queue import exec_pkg::*; (
    input  wire logic   clk_in,
    input  wire logic   rst,
    input  wire logic   flush,
    input  wire logic   enq_valid,
    input  wire entry_t enq_data,
    input  wire logic   deq_ready,
    output logic        deq_valid,
    output entry_t      deq_data,
    output logic        full
);

    entry_t mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] head;
    logic [QPTR_W-1:0] tail;
    logic [QCNT_W-1:0] count;
    logic empty;
    logic push;
    logic pop;

    assign full      = (count == QCNT_W'(QUEUE_DEPTH));
    assign empty     = (count == '0);
    assign deq_valid = !empty;
    assign deq_data  = mem[head];

    assign push = enq_valid && !full;
    assign pop  = deq_ready && !empty;

    // entry storage
    always_ff @(posedge clk_in) begin
        if (push) begin
            mem[tail] <= enq_data;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/issue_router.sv
`timescale 1ns/1ps
`default_nettype none

module issue_router import exec_pkg::*; (
    input  wire logic  issue_valid,
    input  wire op_t   issue_op,
    input  wire tag_t  issue_tag,
    input  wire word_t issue_a,
    input  wire word_t issue_b,
    input  wire logic  alu_full,
    input  wire logic  mul_full,
    output logic       issue_ready,
    output logic       alu_enq_valid,
    output logic       mul_enq_valid,
    output entry_t     enq_data
);

    logic is_mul;

    // only multiplies go to the pipelined unit
    assign is_mul = (issue_op == OP_MUL);

    // ready follows the full flag of the queue this op targets
    assign issue_ready = is_mul ? !mul_full : !alu_full;

    assign alu_enq_valid = issue_valid && !is_mul && !alu_full;
    assign mul_enq_valid = issue_valid && is_mul && !mul_full;

    // both queues see the same packed entry
    assign enq_data = {issue_op, issue_tag, issue_a, issue_b};

endmodule

`default_nettype wire

// File: hw/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit import exec_pkg::*; (
    input  wire logic   head_valid,
    input  wire entry_t head_data,
    input  wire logic   alu_grant,
    output logic        head_ready,
    output logic        alu_wb_valid,
    output tag_t        alu_wb_tag,
    output word_t       alu_wb_data
);

    op_t   op;
    word_t a;
    word_t b;
    logic [5:0] shamt;
    word_t result;

    // unpack queue head
    assign op    = op_t'(head_data[OP_LSB +: OP_W]);
    assign a     = head_data[A_LSB +: WORD_W];
    assign b     = head_data[B_LSB +: WORD_W];
    assign shamt = b[5:0];

    always_comb begin
        case (op)
            OP_ADD: result = a + b;
            OP_SUB: result = a - b;
            OP_AND: result = a & b;
            OP_ORR: result = a | b;
            OP_EOR: result = a ^ b;
            OP_MVN: result = ~a;
            // sign bit fills from the left
            OP_ASR: result = $signed(a) >>> shamt;
            OP_LSL: result = a << shamt;
            default: result = '0;
        endcase
    end

    // offer every cycle the head is valid
    assign alu_wb_valid = head_valid;
    assign alu_wb_tag   = head_data[TAG_LSB +: TAG_W];
    assign alu_wb_data  = result;

    // pop only once the write port is ours
    assign head_ready = head_valid && alu_grant;

endmodule

`default_nettype wire

// File: hw/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit import exec_pkg::*; (
    input  wire logic   clk_in,
    input  wire logic   rst,
    input  wire logic   flush,
    input  wire logic   head_valid,
    input  wire entry_t head_data,
    output logic        head_ready,
    output logic        mul_wb_valid,
    output tag_t        mul_wb_tag,
    output word_t       mul_wb_data
);

    logic [MUL_LATENCY-1:0] stage_valid;
    tag_t  stage_tag  [MUL_LATENCY];
    word_t stage_prod [MUL_LATENCY];
    word_t a;
    word_t b;

    assign a = head_data[A_LSB +: WORD_W];
    assign b = head_data[B_LSB +: WORD_W];

    // fully pipelined so the head is always taken
    assign head_ready = head_valid;

    // valid bits per stage
    always_ff @(posedge clk_in) begin
        if (rst || flush) begin
            stage_valid <= '0;
        end else begin
            stage_valid <= {stage_valid[MUL_LATENCY-2:0], head_valid};
        end
    end

    // tag and product ride along with the valids
    always_ff @(posedge clk_in) begin
        // low half of the product is formed on entry
        stage_tag[0]  <= head_data[TAG_LSB +: TAG_W];
        stage_prod[0] <= a * b;
        for (int i = 1; i < MUL_LATENCY; i++) begin
            stage_tag[i]  <= stage_tag[i-1];
            stage_prod[i] <= stage_prod[i-1];
        end
    end

    assign mul_wb_valid = stage_valid[MUL_LATENCY-1];
    assign mul_wb_tag   = stage_tag[MUL_LATENCY-1];
    assign mul_wb_data  = stage_prod[MUL_LATENCY-1];

endmodule

`default_nettype wire

// File: hw/wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter import exec_pkg::*; (
    input  wire logic  clk_in,
    input  wire logic  rst,
    input  wire logic  flush,
    input  wire logic  mul_wb_valid,
    input  wire tag_t  mul_wb_tag,
    input  wire word_t mul_wb_data,
    input  wire logic  alu_wb_valid,
    input  wire tag_t  alu_wb_tag,
    input  wire word_t alu_wb_data,
    output logic       alu_grant,
    output logic       wb_en,
    output tag_t       wb_tag,
    output word_t      wb_data
);

    // multiplier cannot stall so it always wins the port
    assign alu_grant = !mul_wb_valid;

    always_ff @(posedge clk_in) begin
        if (rst || flush) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= mul_wb_valid || alu_wb_valid;
        end
    end

    // write port payload
    always_ff @(posedge clk_in) begin
        if (mul_wb_valid) begin
            wb_tag  <= mul_wb_tag;
            wb_data <= mul_wb_data;
        end else begin
            wb_tag  <= alu_wb_tag;
            wb_data <= alu_wb_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster import exec_pkg::*; (
    input  wire logic  clk_in,
    input  wire logic  rst,
    input  wire logic  flush,
    input  wire logic  issue_valid,
    input  wire op_t   issue_op,
    input  wire tag_t  issue_tag,
    input  wire word_t issue_a,
    input  wire word_t issue_b,
    output logic       issue_ready,
    output logic       wb_en,
    output tag_t       wb_tag,
    output word_t      wb_data
);

    // router to queues
    logic   alu_enq_valid;
    logic   mul_enq_valid;
    entry_t enq_data;
    logic   alu_full;
    logic   mul_full;

    // queue heads
    logic   alu_deq_valid;
    entry_t alu_deq_data;
    logic   alu_deq_ready;
    logic   mul_deq_valid;
    entry_t mul_deq_data;
    logic   mul_deq_ready;

    // unit results into the write port
    logic  alu_wb_valid;
    tag_t  alu_wb_tag;
    word_t alu_wb_data;
    logic  mul_wb_valid;
    tag_t  mul_wb_tag;
    word_t mul_wb_data;
    logic  alu_grant;

    issue_router u_issue_router (
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_tag     (issue_tag),
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .alu_full      (alu_full),
        .mul_full      (mul_full),
        .issue_ready   (issue_ready),
        .alu_enq_valid (alu_enq_valid),
        .mul_enq_valid (mul_enq_valid),
        .enq_data      (enq_data)
    );

    fu_queue u_alu_queue (
        .clk_in    (clk_in),
        .rst       (rst),
        .flush     (flush),
        .enq_valid (alu_enq_valid),
        .enq_data  (enq_data),
        .deq_ready (alu_deq_ready),
        .deq_valid (alu_deq_valid),
        .deq_data  (alu_deq_data),
        .full      (alu_full)
    );

    fu_queue u_mul_queue (
        .clk_in    (clk_in),
        .rst       (rst),
        .flush     (flush),
        .enq_valid (mul_enq_valid),
        .enq_data  (enq_data),
        .deq_ready (mul_deq_ready),
        .deq_valid (mul_deq_valid),
        .deq_data  (mul_deq_data),
        .full      (mul_full)
    );

    alu_unit u_alu_unit (
        .head_valid   (alu_deq_valid),
        .head_data    (alu_deq_data),
        .alu_grant    (alu_grant),
        .head_ready   (alu_deq_ready),
        .alu_wb_valid (alu_wb_valid),
        .alu_wb_tag   (alu_wb_tag),
        .alu_wb_data  (alu_wb_data)
    );

    mul_unit u_mul_unit (
        .clk_in       (clk_in),
        .rst          (rst),
        .flush        (flush),
        .head_valid   (mul_deq_valid),
        .head_data    (mul_deq_data),
        .head_ready   (mul_deq_ready),
        .mul_wb_valid (mul_wb_valid),
        .mul_wb_tag   (mul_wb_tag),
        .mul_wb_data  (mul_wb_data)
    );

    wb_arbiter u_wb_arbiter (
        .clk_in       (clk_in),
        .rst          (rst),
        .flush        (flush),
        .mul_wb_valid (mul_wb_valid),
        .mul_wb_tag   (mul_wb_tag),
        .mul_wb_data  (mul_wb_data),
        .alu_wb_valid (alu_wb_valid),
        .alu_wb_tag   (alu_wb_tag),
        .alu_wb_data  (alu_wb_data),
        .alu_grant    (alu_grant),
        .wb_en        (wb_en),
        .wb_tag       (wb_tag),
        .wb_data      (wb_data)
    );

endmodule

`default_nettype wire

// File: test/exec_cluster_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_tb import exec_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 3;
    localparam int unsigned RAND_SEED = 32'h328c_8aae;
    localparam int NUM_TAGS = 1 << TAG_W;

    // op counts per test
    localparam int N_EDGE_OPS   = 8 * 4 * 4;
    localparam int N_ALU_RAND   = 32;
    localparam int N_MUL_B2B    = 20;
    localparam int N_BURST      = 16;
    localparam int N_MIX        = 200;
    localparam int N_FLUSH_OPS  = 15;
    localparam int N_POST_FLUSH = 30;
    localparam int NUM_OPS = N_EDGE_OPS + N_ALU_RAND + N_MUL_B2B + 2 * N_BURST + N_MIX
                           + N_FLUSH_OPS + N_POST_FLUSH;
    localparam int OP_CYCLES = MUL_LATENCY + 2 * QUEUE_DEPTH + 4;
    localparam int WATCHDOG_CYCLES = NUM_OPS * OP_CYCLES;
    localparam int DRAIN_LIMIT = 2 * OP_CYCLES;

    // all ones, sign bit, shift amounts 0 and 63 through b
    localparam word_t EDGE_VALS [4] = '{
        64'h0000_0000_0000_0000,
        64'hffff_ffff_ffff_ffff,
        64'h8000_0000_0000_0000,
        64'h0000_0000_0000_003f
    };

    logic  clk_in = 1'b0;
    logic  rst;
    logic  flush;
    logic  issue_valid;
    op_t   issue_op;
    tag_t  issue_tag;
    word_t issue_a;
    word_t issue_b;
    logic  issue_ready;
    logic  wb_en;
    tag_t  wb_tag;
    word_t wb_data;

    // scoreboard indexed by tag
    word_t exp_data   [NUM_TAGS];
    bit    pending    [NUM_TAGS];
    int    class_of   [NUM_TAGS];
    int    seq_no     [NUM_TAGS];
    int    issue_edge [NUM_TAGS];
    int    issued_cnt [2];
    int    retired_cnt [2];

    int   edge_cnt = 0;
    int   errors = 0;
    int   checks = 0;
    tag_t next_tag = '0;
    bit   flush_prev = 1'b0;
    bit   alu_exact = 1'b0;
    bit   alu_stall_seen = 1'b0;
    bit   alu_full_seen = 1'b0;

    exec_cluster u_exec_cluster (
        .clk_in      (clk_in),
        .rst         (rst),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_tag   (issue_tag),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_ready (issue_ready),
        .wb_en       (wb_en),
        .wb_tag      (wb_tag),
        .wb_data     (wb_data)
    );

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    function automatic word_t expected_result(op_t op, word_t a, word_t b);
        int    sh;
        word_t r;
        sh = int'(b[5:0]);
        case (op)
            OP_ADD: r = a + b;
            OP_SUB: r = a + ~b + 64'd1;
            OP_AND: r = a & b;
            OP_ORR: r = a | b;
            OP_EOR: r = a ^ b;
            OP_MVN: r = a ^ 64'hffff_ffff_ffff_ffff;
            // logical shift, then the vacated top bits take the sign
            OP_ASR: r = (a >> sh) | (a[WORD_W-1] ? ~(64'hffff_ffff_ffff_ffff >> sh) : 64'd0);
            OP_LSL: r = a * (64'd1 << sh);
            OP_MUL: begin
                r = '0;
                // shift and add over the bits of b
                for (int i = 0; i < WORD_W; i++) begin
                    if (b[i]) begin
                        r = r + (a << i);
                    end
                end
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic word_t random_word();
        return {$urandom, $urandom};
    endfunction

    function automatic op_t random_alu_op();
        return op_t'($urandom_range(7, 0));
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            n += pending[t];
        end
        return n;
    endfunction

    task automatic check_value(string name, word_t got, word_t want);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_true(bit cond, string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error at %0t: %s", $time, what);
        end
    endtask

    task automatic record_issue();
        int cls;
        cls = (issue_op == OP_MUL) ? 1 : 0;
        check_true(!pending[issue_tag], $sformatf("tag %0d reused while in flight", issue_tag));
        exp_data[issue_tag] = expected_result(issue_op, issue_a, issue_b);
        pending[issue_tag] = 1'b1;
        class_of[issue_tag] = cls;
        seq_no[issue_tag] = issued_cnt[cls];
        issued_cnt[cls]++;
        issue_edge[issue_tag] = edge_cnt;
    endtask

    task automatic check_writeback();
        int lat;
        int cls;
        lat = edge_cnt - issue_edge[wb_tag];
        cls = class_of[wb_tag];
        check_true(pending[wb_tag], $sformatf("tag %0d written back but not in flight", wb_tag));
        if (pending[wb_tag]) begin
            check_value($sformatf("wb_data for tag %0d", wb_tag), wb_data, exp_data[wb_tag]);
            check_true(seq_no[wb_tag] == retired_cnt[cls],
                       $sformatf("tag %0d written back out of issue order", wb_tag));
            retired_cnt[cls] = seq_no[wb_tag] + 1;
            if (cls == 1) begin
                check_value("multiply latency", word_t'(lat), word_t'(MUL_LATENCY + 2));
            end else if (alu_exact) begin
                check_value("alu latency", word_t'(lat), word_t'(2));
            end else begin
                check_true(lat >= 2, "ALU result arrived too early");
            end
            // ALU result that had to wait for the port
            if (cls == 0 && lat > 2) begin
                alu_stall_seen = 1'b1;
            end
            pending[wb_tag] = 1'b0;
        end
    endtask

    task automatic drop_in_flight(input bit report);
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (report) begin
                check_true(!pending[t], $sformatf("tag %0d was never written back", t));
            end
            pending[t] = 1'b0;
        end
        retired_cnt[0] = issued_cnt[0];
        retired_cnt[1] = issued_cnt[1];
    endtask

    // compare process on pre-edge values of all DUT outputs
    always @(posedge clk_in) begin
        if (!rst) begin
            if (flush_prev) begin
                check_value("wb_en after flush", word_t'(wb_en), '0);
            end else if (wb_en) begin
                check_writeback();
            end
            // everything issued before the flush edge is dropped
            if (flush) begin
                drop_in_flight(1'b0);
            end
            if (issue_valid && issue_op == OP_MUL) begin
                check_value("issue_ready for mul op", word_t'(issue_ready), word_t'(1));
            end
            if (issue_valid && issue_op != OP_MUL && !issue_ready) begin
                alu_full_seen = 1'b1;
            end
            if (issue_valid && issue_ready) begin
                record_issue();
            end
        end
        flush_prev = flush;
        edge_cnt++;
    end

    // holds issue_valid until the op is taken
    task automatic send_op(op_t op, word_t a, word_t b);
        issue_valid <= 1'b1;
        issue_op    <= op;
        issue_tag   <= next_tag;
        issue_a     <= a;
        issue_b     <= b;
        @(posedge clk_in);
        while (!issue_ready) begin
            @(posedge clk_in);
        end
        next_tag = next_tag + 1'b1;
    endtask

    task automatic drain();
        int waited;
        issue_valid <= 1'b0;
        waited = 0;
        @(posedge clk_in);
        while (pending_count() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk_in);
            waited++;
        end
        drop_in_flight(1'b1);
        repeat (2) @(posedge clk_in);
    endtask

    initial begin
        int seed_val;
        seed_val = $urandom(RAND_SEED);
        rst = 1'b1;
        flush = 1'b0;
        issue_valid = 1'b0;
        issue_op = OP_ADD;
        issue_tag = '0;
        issue_a = '0;
        issue_b = '0;
        repeat (RST_CYCLES) @(posedge clk_in);
        rst <= 1'b0;

        // idle after reset with both classes ready
        issue_op <= OP_ADD;
        @(posedge clk_in);
        check_value("issue_ready for alu op", word_t'(issue_ready), word_t'(1));
        issue_op <= OP_MUL;
        @(posedge clk_in);
        check_value("issue_ready for mul op", word_t'(issue_ready), word_t'(1));
        repeat (4) begin
            check_value("wb_en while idle", word_t'(wb_en), '0);
            @(posedge clk_in);
        end

        // every ALU opcode on edge operands, then random ones
        alu_exact = 1'b1;
        for (int o = 0; o < 8; o++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    send_op(op_t'(o), EDGE_VALS[i], EDGE_VALS[j]);
                end
            end
        end
        for (int i = 0; i < N_ALU_RAND; i++) begin
            send_op(random_alu_op(), random_word(), random_word());
        end
        drain();
        alu_exact = 1'b0;

        // back-to-back multiplies
        for (int i = 0; i < N_MUL_B2B; i++) begin
            send_op(OP_MUL, random_word(), random_word());
        end
        drain();

        // multiply burst that fills the ALU queue, then random mix
        for (int i = 0; i < N_BURST; i++) begin
            send_op(OP_MUL, random_word(), random_word());
        end
        for (int i = 0; i < N_BURST; i++) begin
            send_op(random_alu_op(), random_word(), random_word());
        end
        for (int i = 0; i < N_MIX; i++) begin
            send_op($urandom_range(1, 0) ? OP_MUL : random_alu_op(),
                    random_word(), random_word());
        end
        drain();
        check_true(alu_stall_seen, "ALU was never held back by a multiply writeback");
        check_true(alu_full_seen, "issue_ready never dropped for a full ALU queue");

        // flush with queues and multiplier busy
        for (int i = 0; i < N_FLUSH_OPS; i++) begin
            send_op((i >= 8 && i < 12) ? random_alu_op() : OP_MUL,
                    random_word(), random_word());
        end
        issue_valid <= 1'b0;
        flush <= 1'b1;
        @(posedge clk_in);
        flush <= 1'b0;
        repeat (2) @(posedge clk_in);
        for (int i = 0; i < N_POST_FLUSH; i++) begin
            send_op($urandom_range(1, 0) ? OP_MUL : random_alu_op(),
                    random_word(), random_word());
        end
        drain();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // bound scales with the op count
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hw/exec_pkg.sv
hw/fu_queue.sv
hw/issue_router.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/wb_arbiter.sv
hw/exec_cluster.sv
test/exec_cluster_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module exec_cluster_tb \
    -f src.f -o exec_cluster_sim

./obj_dir/exec_cluster_sim > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
